// File: cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, MIPS numbering where one exists
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SB    = 6'h28,
    OP_HALT  = 6'h3f
  } opcode_e;

  typedef enum logic [5:0] {
    F_ADD = 6'h20,
    F_SUB = 6'h22,
    F_AND = 6'h24,
    F_OR  = 6'h25,
    F_XOR = 6'h26,
    F_SLT = 6'h2a
  } funct_e;

  // Register format
  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] shamt;  // Not used by this subset
    funct_e    funct;
  } r_fmt_t;

  // Immediate format
  typedef struct packed {
    opcode_e     opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// File: reg_file.sv
module reg_file (
  input  logic               clock,
  input  logic               arst_n,
  input  cpu_pkg::reg_addr_t rd_addr1,
  input  cpu_pkg::reg_addr_t rd_addr2,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  logic               wr_en,
  input  cpu_pkg::word_t     wr_data,
  output cpu_pkg::word_t     rd_data1,
  output cpu_pkg::word_t     rd_data2
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;  // r0 stays zero
    end
  end

  // Combinational read ports
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

// File: tcm.sv
module tcm #(
  parameter int MEM_WORDS = 256
) (
  input  logic           clock,
  input  logic           arst_n,
  // Core request port, byte addresses
  input  cpu_pkg::word_t cpu_addr,
  input  cpu_pkg::word_t cpu_wr_data,
  input  logic [3:0]     cpu_wr_be,
  input  logic           cpu_rd,
  input  logic           cpu_wr,
  output cpu_pkg::word_t cpu_rd_data,
  output logic           cpu_waitrequest,
  // Host port, byte addresses
  input  logic           host_wr,
  input  cpu_pkg::word_t host_addr,
  input  cpu_pkg::word_t host_wr_data,
  input  cpu_pkg::word_t host_rd_addr,
  output cpu_pkg::word_t host_rd_data
);
  import cpu_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  word_t            mem [MEM_WORDS];
  word_t            rd_data_q;
  logic             rd_pending;  // Wait state done, data ready
  logic [IDX_W-1:0] cpu_idx;
  logic [IDX_W-1:0] host_idx;
  logic [IDX_W-1:0] host_rd_idx;

  // Word index, upper address bits wrap
  assign cpu_idx     = cpu_addr[IDX_W+1:2];
  assign host_idx    = host_addr[IDX_W+1:2];
  assign host_rd_idx = host_rd_addr[IDX_W+1:2];

  assign cpu_waitrequest = cpu_rd && !rd_pending;
  assign cpu_rd_data     = rd_data_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) rd_pending <= 1'b0;
    else         rd_pending <= cpu_rd && !rd_pending;
  end

  always_ff @(posedge clock) begin
    if (cpu_waitrequest) rd_data_q <= mem[cpu_idx];  // First read cycle
    if (cpu_wr) begin
      for (int b = 0; b < 4; b++) begin
        if (cpu_wr_be[b]) mem[cpu_idx][8*b +: 8] <= cpu_wr_data[8*b +: 8];
      end
    end
    // Later assignment, so the host wins a same-word collision
    if (host_wr) mem[host_idx] <= host_wr_data;
    host_rd_data <= mem[host_rd_idx];
  end

endmodule

// File: cpu_core.sv
module cpu_core (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               start,
  output logic               halted,
  // Instruction fetch
  output cpu_pkg::word_t     imem_addr,
  output logic               imem_rd,
  input  cpu_pkg::word_t     imem_data,
  input  logic               imem_waitrequest,
  // Data access
  output cpu_pkg::word_t     dmem_addr,
  output logic               dmem_rd,
  output logic               dmem_wr,
  output logic [3:0]         dmem_wr_be,
  output cpu_pkg::word_t     dmem_wr_data,
  input  cpu_pkg::word_t     dmem_data,
  input  logic               dmem_waitrequest,
  // Register file
  output cpu_pkg::reg_addr_t rf_rd_addr1,
  output cpu_pkg::reg_addr_t rf_rd_addr2,
  output logic               rf_wr_en,
  output cpu_pkg::reg_addr_t rf_wr_addr,
  output cpu_pkg::word_t     rf_wr_data,
  input  cpu_pkg::word_t     rf_rd_data1,
  input  cpu_pkg::word_t     rf_rd_data2,
  output cpu_pkg::word_t     retire_pc
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALT
  } state_e;

  state_e state;
  word_t  pc;       // Address of the instruction in flight
  instr_t ir;
  word_t  op_a;
  word_t  op_b;
  word_t  result;   // ALU output, memory address or load data

  word_t  alu_out;
  word_t  imm_ext;
  word_t  pc_plus4;
  word_t  br_target;
  logic   is_rtype;
  logic   is_addi;
  logic   is_lw;
  logic   is_sb;
  logic   is_beq;
  logic   is_halt;

  // Opcode decode, immediate view
  assign is_rtype = (ir.i.opcode == OP_RTYPE);
  assign is_addi  = (ir.i.opcode == OP_ADDI);
  assign is_lw    = (ir.i.opcode == OP_LW);
  assign is_sb    = (ir.i.opcode == OP_SB);
  assign is_beq   = (ir.i.opcode == OP_BEQ);
  assign is_halt  = (ir.i.opcode == OP_HALT);

  assign imm_ext   = {{16{ir.i.imm[15]}}, ir.i.imm};
  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};  // Word offset

  always_comb begin
    alu_out = '0;
    if (is_rtype) begin
      case (ir.r.funct)
        F_ADD:   alu_out = op_a + op_b;
        F_SUB:   alu_out = op_a - op_b;
        F_AND:   alu_out = op_a & op_b;
        F_OR:    alu_out = op_a | op_b;
        F_XOR:   alu_out = op_a ^ op_b;
        F_SLT:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
        default: alu_out = '0;
      endcase
    end else begin
      alu_out = op_a + imm_ext;  // addi result or lw/sb address
    end
  end

  // Sequencer and program counter
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            pc    <= RESET_PC;
            state <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (!imem_waitrequest) state <= S_DECODE;
        end
        S_DECODE: state <= is_halt ? S_HALT : S_EXEC;
        S_EXEC: begin
          if (is_lw || is_sb) begin
            state <= S_MEM;
          end else if (is_rtype || is_addi) begin
            state <= S_WB;
          end else begin
            // beq, and unknown opcodes fall through as no-ops
            pc    <= (is_beq && op_a == op_b) ? br_target : pc_plus4;
            state <= S_FETCH;
          end
        end
        S_MEM: begin
          if (!dmem_waitrequest) begin
            if (is_lw) begin
              state <= S_WB;
            end else begin
              pc    <= pc_plus4;
              state <= S_FETCH;
            end
          end
        end
        S_WB: begin
          pc    <= pc_plus4;
          state <= S_FETCH;
        end
        S_HALT:  state <= S_HALT;  // Left only through reset
        default: state <= S_IDLE;
      endcase
    end
  end

  // Instruction and operand latches
  always_ff @(posedge clock) begin
    if (state == S_FETCH && !imem_waitrequest) ir <= imem_data;
    if (state == S_DECODE) begin
      op_a <= rf_rd_data1;
      op_b <= rf_rd_data2;
    end
    if (state == S_EXEC) result <= alu_out;
    if (state == S_MEM && is_lw && !dmem_waitrequest) result <= dmem_data;
  end

  assign imem_addr = pc;
  assign imem_rd   = (state == S_FETCH);

  assign dmem_addr    = result;
  assign dmem_rd      = (state == S_MEM) && is_lw;
  assign dmem_wr      = (state == S_MEM) && is_sb;
  assign dmem_wr_be   = 4'b0001 << result[1:0];  // Lane from low address bits
  assign dmem_wr_data = {4{op_b[7:0]}};

  assign rf_rd_addr1 = ir.i.rs;
  assign rf_rd_addr2 = ir.i.rt;
  assign rf_wr_en    = (state == S_WB);
  assign rf_wr_addr  = is_rtype ? ir.r.rd : ir.i.rt;
  assign rf_wr_data  = result;

  assign retire_pc = pc;
  assign halted    = (state == S_HALT);

endmodule

// File: cpu_top.sv
module cpu_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               start,
  output logic               halted,
  // Host load into instruction memory
  input  logic               imem_load_wr,
  input  cpu_pkg::word_t     imem_load_addr,
  input  cpu_pkg::word_t     imem_load_data,
  // Host load and peek on data memory
  input  logic               dmem_load_wr,
  input  cpu_pkg::word_t     dmem_load_addr,
  input  cpu_pkg::word_t     dmem_load_data,
  input  cpu_pkg::word_t     dmem_peek_addr,
  output cpu_pkg::word_t     dmem_peek_data,
  // Retirement trace, mirrors the register-file write port
  output logic               trace_wr_en,
  output cpu_pkg::reg_addr_t trace_wr_addr,
  output cpu_pkg::word_t     trace_wr_data,
  output cpu_pkg::word_t     retire_pc
);
  import cpu_pkg::*;

  word_t      imem_addr;
  logic       imem_rd;
  word_t      imem_data;
  logic       imem_waitrequest;

  word_t      dmem_addr;
  logic       dmem_rd;
  logic       dmem_wr;
  logic [3:0] dmem_wr_be;
  word_t      dmem_wr_data;
  word_t      dmem_data;
  logic       dmem_waitrequest;

  reg_addr_t  rf_rd_addr1;
  reg_addr_t  rf_rd_addr2;
  word_t      rf_rd_data1;
  word_t      rf_rd_data2;

  cpu_core core_i (
    .clock            (clock),
    .arst_n           (arst_n),
    .start            (start),
    .halted           (halted),
    .imem_addr        (imem_addr),
    .imem_rd          (imem_rd),
    .imem_data        (imem_data),
    .imem_waitrequest (imem_waitrequest),
    .dmem_addr        (dmem_addr),
    .dmem_rd          (dmem_rd),
    .dmem_wr          (dmem_wr),
    .dmem_wr_be       (dmem_wr_be),
    .dmem_wr_data     (dmem_wr_data),
    .dmem_data        (dmem_data),
    .dmem_waitrequest (dmem_waitrequest),
    .rf_rd_addr1      (rf_rd_addr1),
    .rf_rd_addr2      (rf_rd_addr2),
    .rf_wr_en         (trace_wr_en),
    .rf_wr_addr       (trace_wr_addr),
    .rf_wr_data       (trace_wr_data),
    .rf_rd_data1      (rf_rd_data1),
    .rf_rd_data2      (rf_rd_data2),
    .retire_pc        (retire_pc)
  );

  reg_file reg_file_i (
    .clock    (clock),
    .arst_n   (arst_n),
    .rd_addr1 (rf_rd_addr1),
    .rd_addr2 (rf_rd_addr2),
    .wr_addr  (trace_wr_addr),
    .wr_en    (trace_wr_en),
    .wr_data  (trace_wr_data),
    .rd_data1 (rf_rd_data1),
    .rd_data2 (rf_rd_data2)
  );

  // Instruction memory, core side is read only
  tcm #(
    .MEM_WORDS (MEM_WORDS)
  ) imem_i (
    .clock           (clock),
    .arst_n          (arst_n),
    .cpu_addr        (imem_addr),
    .cpu_wr_data     ('0),
    .cpu_wr_be       (4'b0000),
    .cpu_rd          (imem_rd),
    .cpu_wr          (1'b0),
    .cpu_rd_data     (imem_data),
    .cpu_waitrequest (imem_waitrequest),
    .host_wr         (imem_load_wr),
    .host_addr       (imem_load_addr),
    .host_wr_data    (imem_load_data),
    .host_rd_addr    ('0),
    .host_rd_data    ()
  );

  tcm #(
    .MEM_WORDS (MEM_WORDS)
  ) dmem_i (
    .clock           (clock),
    .arst_n          (arst_n),
    .cpu_addr        (dmem_addr),
    .cpu_wr_data     (dmem_wr_data),
    .cpu_wr_be       (dmem_wr_be),
    .cpu_rd          (dmem_rd),
    .cpu_wr          (dmem_wr),
    .cpu_rd_data     (dmem_data),
    .cpu_waitrequest (dmem_waitrequest),
    .host_wr         (dmem_load_wr),
    .host_addr       (dmem_load_addr),
    .host_wr_data    (dmem_load_data),
    .host_rd_addr    (dmem_peek_addr),
    .host_rd_data    (dmem_peek_data)
  );

endmodule

// File: tb_cpu_properties.sv
module tb_cpu_properties (
  input logic               clock,
  input logic               arst_n,
  input logic               halted,
  input cpu_pkg::word_t     imem_addr,
  input logic               imem_rd,
  input logic               imem_waitrequest,
  input cpu_pkg::word_t     dmem_addr,
  input logic               dmem_rd,
  input logic               dmem_wr,
  input logic               dmem_waitrequest,
  input cpu_pkg::reg_addr_t rf_rd_addr1,
  input cpu_pkg::reg_addr_t rf_rd_addr2,
  input cpu_pkg::word_t     rf_rd_data1,
  input cpu_pkg::word_t     rf_rd_data2
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned failures = 0;  // Watched from the testbench top

  // A stalled request keeps its strobe and address
  fetch_hold: assert property (@(posedge clock) disable iff (!arst_n)
    imem_rd && imem_waitrequest |=> imem_rd && $stable(imem_addr))
    else begin
      $error("fetch address moved while waitrequest was high");
      failures++;
    end

  data_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (dmem_rd || dmem_wr) && dmem_waitrequest |=> (dmem_rd || dmem_wr) && $stable(dmem_addr))
    else begin
      $error("data address moved while waitrequest was high");
      failures++;
    end

  strobe_excl: assert property (@(posedge clock) disable iff (!arst_n)
    !(dmem_rd && dmem_wr) && !(imem_rd && (dmem_rd || dmem_wr)))
    else begin
      $error("two memory strobes high in one cycle");
      failures++;
    end

  // r0 reads back zero, so any write to it was dropped
  zero_reg_1: assert property (@(posedge clock) disable iff (!arst_n)
    rf_rd_addr1 == 5'd0 |-> rf_rd_data1 == '0)
    else begin
      $error("register 0 read nonzero on port 1");
      failures++;
    end

  zero_reg_2: assert property (@(posedge clock) disable iff (!arst_n)
    rf_rd_addr2 == 5'd0 |-> rf_rd_data2 == '0)
    else begin
      $error("register 0 read nonzero on port 2");
      failures++;
    end

  halt_sticky: assert property (@(posedge clock) disable iff (!arst_n)
    halted |=> halted)
    else begin
      $error("halted fell outside reset");
      failures++;
    end

endmodule

// File: tb_cpu.sv
module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int IDX_W      = $clog2(MEM_WORDS);
  localparam int DATA_WORDS = 16;    // Tests keep data accesses in bytes 0..63
  localparam int MAX_STEPS  = 1000;

  logic      clock = 1'b0;
  logic      arst_n;
  logic      start;
  logic      halted;
  logic      imem_load_wr;
  word_t     imem_load_addr;
  word_t     imem_load_data;
  logic      dmem_load_wr;
  word_t     dmem_load_addr;
  word_t     dmem_load_data;
  word_t     dmem_peek_addr;
  word_t     dmem_peek_data;
  logic      trace_wr_en;
  reg_addr_t trace_wr_addr;
  word_t     trace_wr_data;
  word_t     retire_pc;

  word_t     prog [MEM_WORDS];
  int        prog_len;
  word_t     model_mem [MEM_WORDS];  // Expected data memory
  reg_addr_t exp_reg [$];
  word_t     exp_data [$];
  word_t     exp_pc [$];
  int        writes_seen;
  int        cycles;
  int        cycle_limit = 200;
  integer    seed = 63206;

  cpu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) dut_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .start          (start),
    .halted         (halted),
    .imem_load_wr   (imem_load_wr),
    .imem_load_addr (imem_load_addr),
    .imem_load_data (imem_load_data),
    .dmem_load_wr   (dmem_load_wr),
    .dmem_load_addr (dmem_load_addr),
    .dmem_load_data (dmem_load_data),
    .dmem_peek_addr (dmem_peek_addr),
    .dmem_peek_data (dmem_peek_data),
    .trace_wr_en    (trace_wr_en),
    .trace_wr_addr  (trace_wr_addr),
    .trace_wr_data  (trace_wr_data),
    .retire_pc      (retire_pc)
  );

  bind cpu_core tb_cpu_properties props_i (
    .clock            (clock),
    .arst_n           (arst_n),
    .halted           (halted),
    .imem_addr        (imem_addr),
    .imem_rd          (imem_rd),
    .imem_waitrequest (imem_waitrequest),
    .dmem_addr        (dmem_addr),
    .dmem_rd          (dmem_rd),
    .dmem_wr          (dmem_wr),
    .dmem_waitrequest (dmem_waitrequest),
    .rf_rd_addr1      (rf_rd_addr1),
    .rf_rd_addr2      (rf_rd_addr2),
    .rf_rd_data1      (rf_rd_data1),
    .rf_rd_data2      (rf_rd_data2)
  );

  always #10 clock = ~clock;

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_reg(string name, reg_addr_t expected, reg_addr_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  function automatic word_t r_type(funct_e funct, reg_addr_t rd, reg_addr_t rs,
                                   reg_addr_t rt);
    instr_t ins;
    ins.r.opcode = OP_RTYPE;
    ins.r.rs     = rs;
    ins.r.rt     = rt;
    ins.r.rd     = rd;
    ins.r.shamt  = '0;
    ins.r.funct  = funct;
    return ins;
  endfunction

  function automatic word_t i_type(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                   logic [15:0] imm);
    instr_t ins;
    ins.i.opcode = op;
    ins.i.rs     = rs;
    ins.i.rt     = rt;
    ins.i.imm    = imm;
    return ins;
  endfunction

  task automatic emit(word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Initial data depends on the whole byte address
  function automatic word_t data_fill(word_t addr);
    return (addr * 32'h0101_0007) ^ 32'hC0DE_5A00 ^ {addr[7:0], addr[31:8]};
  endfunction

  function automatic void record_write(reg_addr_t rd, word_t val, word_t pc);
    exp_reg.push_back(rd);
    exp_data.push_back(val);
    exp_pc.push_back(pc);
  endfunction

  // Instruction-set model that returns steps run or -1 at the step limit
  function automatic int run_model(int max_steps);
    word_t  regs [32];
    word_t  pc;
    word_t  a;
    word_t  b;
    word_t  imm;
    word_t  addr;
    word_t  val;
    instr_t ins;
    int     steps;
    bit     done;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    pc    = RESET_PC;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < max_steps) begin
      ins  = prog[pc[IDX_W+1:2]];
      a    = regs[ins.i.rs];
      b    = regs[ins.i.rt];
      imm  = {{16{ins.i.imm[15]}}, ins.i.imm};
      addr = a + imm;
      steps++;
      case (ins.i.opcode)
        OP_RTYPE: begin
          case (ins.r.funct)
            F_ADD:   val = a + b;
            F_SUB:   val = a - b;
            F_AND:   val = a & b;
            F_OR:    val = a | b;
            F_XOR:   val = a ^ b;
            F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: val = '0;
          endcase
          record_write(ins.r.rd, val, pc);
          if (ins.r.rd != 5'd0) regs[ins.r.rd] = val;
          pc = pc + 4;
        end
        OP_ADDI, OP_LW: begin
          val = (ins.i.opcode == OP_LW) ? model_mem[addr[IDX_W+1:2]] : addr;
          record_write(ins.i.rt, val, pc);
          if (ins.i.rt != 5'd0) regs[ins.i.rt] = val;
          pc = pc + 4;
        end
        OP_SB: begin
          model_mem[addr[IDX_W+1:2]][8*addr[1:0] +: 8] = b[7:0];  // Lane from addr
          pc = pc + 4;
        end
        OP_BEQ:  pc = (a == b) ? pc + 4 + (imm << 2) : pc + 4;
        OP_HALT: done = 1'b1;
        default: pc = pc + 4;
      endcase
    end
    return done ? steps : -1;
  endfunction

  // Every register write must match the next model entry
  always @(negedge clock) begin
    if (arst_n && trace_wr_en) begin
      if (exp_reg.size() == 0) begin
        $display("Register write at %0t that the model does not expect", $time);
        abort_run();
      end else begin
        check_reg("trace_wr_addr", exp_reg.pop_front(), trace_wr_addr);
        check_word("trace_wr_data", exp_data.pop_front(), trace_wr_data);
        check_word("retire_pc", exp_pc.pop_front(), retire_pc);
        writes_seen++;
      end
    end
  end

  always @(negedge clock) begin
    if (dut_i.core_i.props_i.failures != 0) begin
      $display("A core handshake or trace assertion failed before %0t", $time);
      abort_run();
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles at %0t, core never halted", cycles, $time);
      abort_run();
    end
  end

  // Asserts reset at once and holds it for 5 cycles
  task automatic drive_reset();
    cycles      = 0;
    cycle_limit = 200;  // Load overhead
    arst_n      = 1'b0;
    @(negedge clock);
    if (halted || trace_wr_en) begin
      $display("halted or trace_wr_en still high in reset at %0t", $time);
      abort_run();
    end
    repeat (5) @(posedge clock);
    #2;
    arst_n = 1'b1;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #2;
    drive_reset();
  endtask

  task automatic load_and_model();
    int steps;
    exp_reg.delete();
    exp_data.delete();
    exp_pc.delete();
    writes_seen = 0;
    for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = data_fill(32'(i * 4));
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clock);
      #2;
      imem_load_wr   = 1'b1;
      imem_load_addr = 32'(i * 4);
      imem_load_data = prog[i];
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      @(posedge clock);
      #2;
      imem_load_wr   = 1'b0;
      dmem_load_wr   = 1'b1;
      dmem_load_addr = 32'(i * 4);
      dmem_load_data = model_mem[i];
    end
    @(posedge clock);
    #2;
    dmem_load_wr = 1'b0;
    steps = run_model(MAX_STEPS);
    if (steps < 0) begin
      $display("Reference model did not reach halt in %0d steps", MAX_STEPS);
      abort_run();
    end
    cycle_limit += 10 * steps;
  endtask

  task automatic pulse_start();
    @(posedge clock);
    #2;
    start = 1'b1;
    @(posedge clock);
    #2;
    start = 1'b0;
  endtask

  task automatic finish_and_peek();
    while (!halted) @(negedge clock);
    if (exp_reg.size() != 0) begin
      $display("Core halted with %0d expected register writes missing", exp_reg.size());
      abort_run();
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      @(posedge clock);
      #2;
      dmem_peek_addr = 32'(i * 4);
      @(posedge clock);
      @(negedge clock);  // Registered peek data
      check_word("dmem_peek_data", model_mem[i], dmem_peek_data);
    end
    if (!halted) begin
      $display("halted fell while the core was stopped at %0t", $time);
      abort_run();
    end
  endtask

  task automatic run_program();
    apply_reset();
    load_and_model();
    pulse_start();
    finish_and_peek();
  endtask

  task automatic build_store_prog();
    prog_len = 0;
    emit(i_type(OP_ADDI, 1, 0, 16'h0011));
    emit(i_type(OP_ADDI, 2, 0, 16'hFFFE));
    emit(i_type(OP_ADDI, 3, 0, 16'h007F));
    emit(i_type(OP_ADDI, 4, 0, 16'h0080));
    emit(i_type(OP_SB, 1, 0, 16'd16));  // One byte per lane of word 4
    emit(i_type(OP_SB, 2, 0, 16'd17));
    emit(i_type(OP_SB, 3, 0, 16'd18));
    emit(i_type(OP_SB, 4, 0, 16'd19));
    emit(i_type(OP_LW, 5, 0, 16'd16));
    emit(i_type(OP_ADDI, 6, 0, 16'd40));
    emit(i_type(OP_SB, 2, 6, 16'd1));
    emit(i_type(OP_LW, 7, 6, 16'd0));
    emit(i_type(OP_LW, 8, 0, 16'd60));  // Untouched word
    emit(i_type(OP_HALT, 0, 0, 16'd0));
  endtask

  task automatic build_random_prog();
    funct_e funcs [6];
    int     kind;
    funcs    = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLT};
    prog_len = 0;
    for (int n = 0; n < 40; n++) begin
      kind = rand_below(5);
      if (kind < 2) begin
        emit(r_type(funcs[rand_below(6)], 5'(rand_below(8)), 5'(rand_below(8)),
                    5'(rand_below(8))));
      end else if (kind == 2) begin
        emit(i_type(OP_ADDI, 5'(rand_below(8)), 5'(rand_below(8)), 16'($random(seed))));
      end else if (kind == 3) begin
        emit(i_type(OP_LW, 5'(rand_below(8)), 0, 16'(rand_below(DATA_WORDS) * 4)));
      end else begin
        emit(i_type(OP_SB, 5'(rand_below(8)), 0, 16'(rand_below(DATA_WORDS * 4))));
      end
    end
    emit(i_type(OP_HALT, 0, 0, 16'd0));
  endtask

  initial begin
    arst_n         = 1'b0;
    start          = 1'b0;
    imem_load_wr   = 1'b0;
    imem_load_addr = '0;
    imem_load_data = '0;
    dmem_load_wr   = 1'b0;
    dmem_load_addr = '0;
    dmem_load_data = '0;
    dmem_peek_addr = '0;
    cycles         = 0;
    writes_seen    = 0;

    $display("Test 1: R-type functions and addi");
    prog_len = 0;
    emit(i_type(OP_ADDI, 1, 0, 16'd100));
    emit(i_type(OP_ADDI, 2, 0, 16'hFFF9));    // -7
    emit(i_type(OP_ADDI, 3, 0, 16'h7FFF));
    emit(r_type(F_ADD, 4, 1, 2));
    emit(r_type(F_SUB, 5, 2, 1));
    emit(r_type(F_AND, 6, 1, 3));
    emit(r_type(F_OR, 7, 2, 3));
    emit(r_type(F_XOR, 8, 1, 2));
    emit(r_type(F_SLT, 9, 2, 1));              // Signed compare
    emit(r_type(F_SLT, 10, 1, 2));
    emit(r_type(F_SLT, 11, 5, 2));
    emit(i_type(OP_ADDI, 12, 2, 16'h8000));
    emit(i_type(OP_HALT, 0, 0, 16'd0));
    run_program();

    $display("Test 2: writes to register 0");
    prog_len = 0;
    emit(i_type(OP_ADDI, 0, 0, 16'd55));
    emit(i_type(OP_ADDI, 1, 0, 16'd9));
    emit(r_type(F_ADD, 0, 1, 1));
    emit(r_type(F_ADD, 2, 0, 1));
    emit(r_type(F_SUB, 3, 0, 1));
    emit(i_type(OP_HALT, 0, 0, 16'd0));
    run_program();

    $display("Test 3: byte stores then word loads");
    build_store_prog();
    run_program();

    $display("Test 4: beq taken, not taken, backward loop");
    prog_len = 0;
    emit(i_type(OP_ADDI, 1, 0, 16'd3));
    emit(i_type(OP_ADDI, 2, 0, 16'd0));
    emit(i_type(OP_ADDI, 2, 2, 16'd5));        // Loop body
    emit(i_type(OP_ADDI, 1, 1, 16'hFFFF));
    emit(i_type(OP_BEQ, 0, 1, 16'd1));         // Leave at zero
    emit(i_type(OP_BEQ, 0, 0, 16'hFFFC));      // Back to the body
    emit(i_type(OP_BEQ, 1, 2, 16'd5));
    emit(r_type(F_ADD, 3, 2, 1));
    emit(i_type(OP_HALT, 0, 0, 16'd0));
    run_program();

    $display("Test 5: random program");
    build_random_prog();
    run_program();

    $display("Test 6: reset in the middle of a program");
    build_store_prog();
    apply_reset();
    load_and_model();
    pulse_start();
    // Reset lands in the write-back cycle of the fifth register write
    while (writes_seen < 4 || !trace_wr_en) begin
      @(posedge clock);
      #2;
    end
    drive_reset();
    load_and_model();
    pulse_start();
    finish_and_peek();

    if (dut_i.core_i.props_i.failures == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("A core assertion failed near the end of the run");
      abort_run();
    end
  end

endmodule

// File: sources.f
cpu_pkg.sv
reg_file.sv
tcm.sv
cpu_core.sv
cpu_top.sv
tb_cpu_properties.sv
tb_cpu.sv
